// File: hdl/adc_acq_macros.svh
`ifndef ADC_ACQ_MACROS_SVH
`define ADC_ACQ_MACROS_SVH

// contents tags in bits 131:128 of every word
`define ACQ_TAG_FILL 4'd1
`define ACQ_TAG_WAVE 4'd2
`define ACQ_TAG_DATA 4'd3
`define ACQ_TAG_CHK  4'd4

// header marker, never seen in sign-extended data
`define ACQ_HDR_MARK 2'b01

// sample width without the over-range bit
`define ACQ_SAMPLE_W 12

`endif

// File: hdl/adc_acq_pkg.sv
`default_nettype none

package adc_acq_pkg;

    typedef logic [25:0]  pair_t;           // two 13-bit samples, over-range in bit 0 of each
    typedef pair_t [3:0]  burst_t;          // four pairs, pair 0 oldest
    typedef logic [3:0]   acq_tag_t;        // contents tag
    typedef logic [127:0] payload_t;        // header, data or checksum body
    typedef logic [22:0]  wave_num_t;       // waveform index
    typedef logic [22:0]  burst_cnt_t;      // word count and word address
    typedef logic [41:0]  trig_time_t;      // trigger time in clock cycles
    typedef logic [11:0]  chan_tag_t;       // channel tag

    typedef struct packed {
        acq_tag_t tag;                      // bits 131:128
        payload_t payload;                  // bits 127:0
    } acq_word_t;

    typedef struct packed {
        chan_tag_t   channel_tag;
        logic [23:0] fill_num;
        logic [1:0]  fill_type;
        logic [13:0] num_bursts;            // data words per trigger
        logic [15:0] pre_trig;              // copied into the headers only
    } acq_cfg_t;

    typedef struct packed {
        logic fill_hdr;                     // one-hot word selects
        logic wave_hdr;
        logic dat;
        logic chk;
        logic chk_init;                     // clear the running checksum
    } word_sel_t;

    typedef struct packed {
        wave_num_t  waveform_num;
        burst_cnt_t waveform_start_adr;
        trig_time_t trigger_time;
        burst_cnt_t num_fill_bursts;        // words in the fill so far
    } wave_info_t;

    typedef enum logic [2:0] {
        st_idle,
        st_armed,
        st_wave_hdr,
        st_data,
        st_fill_hdr,
        st_checksum
    } seq_state_t;

endpackage

`default_nettype wire

// File: hdl/sample_gather.sv
`default_nettype none

module sample_gather (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire adc_acq_pkg::pair_t    pair,
    input  wire                        pair_valid,
    input  wire                        fill_start,
    input  wire                        burst_take,
    output adc_acq_pkg::burst_t        burst,
    output logic                       burst_valid,
    output logic                       overflow
);

    logic [1:0]                 slot;         // next staging slot
    adc_acq_pkg::pair_t [2:0]   stage;        // first three pairs of a burst
    logic                       last_pair;    // fourth pair arriving now
    logic                       hold_free;    // holding register can take a burst

    assign last_pair = pair_valid && (slot == 2'd3);
    assign hold_free = !burst_valid || burst_take;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot        <= 2'd0;
            burst_valid <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            if (pair_valid) slot <= slot + 2'd1;     // wraps every four pairs
            if (fill_start) overflow <= 1'b0;
            if (burst_take) burst_valid <= 1'b0;
            if (last_pair) begin
                if (hold_free) burst_valid <= 1'b1;
                else overflow <= 1'b1;               // sticky, new burst is lost
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pair_valid && (slot != 2'd3)) stage[slot] <= pair;
        if (last_pair && hold_free) burst <= {pair, stage[2], stage[1], stage[0]};
    end

    // the sequencer only consumes a burst that is actually held
    a_take_valid: assert property (@(posedge clk) disable iff (!rst_n)
        burst_take |-> burst_valid);

endmodule

`default_nettype wire

// File: hdl/fill_sequencer.sv
`default_nettype none

module fill_sequencer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         trigger,
    input  wire                         fill_start,
    input  wire                         fill_stop,
    input  wire adc_acq_pkg::acq_cfg_t  cfg,
    input  wire                         burst_valid,
    output logic                        burst_take,
    input  wire                         word_ready,
    output adc_acq_pkg::word_sel_t      sel,
    output logic                        out_valid,
    output adc_acq_pkg::wave_info_t     info,
    output logic                        done
);

    adc_acq_pkg::seq_state_t  state;
    adc_acq_pkg::burst_cnt_t  word_cnt;     // words issued in this fill
    adc_acq_pkg::wave_num_t   wave_cnt;     // completed waveforms
    adc_acq_pkg::burst_cnt_t  wave_adr;     // header address of current waveform
    adc_acq_pkg::trig_time_t  time_cnt;     // free-running cycle count
    adc_acq_pkg::trig_time_t  trig_time;    // time of the last accepted trigger
    logic [13:0]              burst_cnt;    // data words in current waveform
    logic                     sel_any;
    logic                     go;           // writer idle and nothing in flight

    assign sel_any    = sel.fill_hdr || sel.wave_hdr || sel.dat || sel.chk;
    assign go         = word_ready && !sel_any && !out_valid;
    assign burst_take = sel.dat;            // gather frees the burst as mux latches it

    assign info = '{waveform_num:       wave_cnt,
                    waveform_start_adr: wave_adr,
                    trigger_time:       trig_time,
                    num_fill_bursts:    word_cnt};

    ////////////////////////////////////////////////////////////
    // fill ordering FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= adc_acq_pkg::st_idle;
            sel       <= '0;
            out_valid <= 1'b0;
            done      <= 1'b0;
            time_cnt  <= '0;
            word_cnt  <= '0;
            wave_cnt  <= '0;
            burst_cnt <= '0;
        end else begin
            sel       <= '0;                    // selects are single-cycle
            done      <= 1'b0;
            out_valid <= sel_any;               // mux output is ready one cycle later
            time_cnt  <= time_cnt + 42'd1;
            if (sel.wave_hdr && (cfg.num_bursts == 14'd0)) begin
                wave_cnt <= wave_cnt + 23'd1;   // header-only waveform, counted once formatted
            end
            case (state)
                adc_acq_pkg::st_idle: begin
                    if (fill_start) begin
                        sel.chk_init <= 1'b1;
                        word_cnt     <= '0;
                        wave_cnt     <= '0;
                        state        <= adc_acq_pkg::st_armed;
                    end
                end
                adc_acq_pkg::st_armed: begin
                    if (trigger) state <= adc_acq_pkg::st_wave_hdr;
                    else if (fill_stop) state <= adc_acq_pkg::st_fill_hdr;
                end
                adc_acq_pkg::st_wave_hdr: begin
                    if (go) begin
                        sel.wave_hdr <= 1'b1;
                        word_cnt     <= word_cnt + 23'd1;
                        burst_cnt    <= '0;
                        if (cfg.num_bursts == 14'd0) begin  // header-only waveform
                            state    <= adc_acq_pkg::st_armed;
                        end else begin
                            state    <= adc_acq_pkg::st_data;
                        end
                    end
                end
                adc_acq_pkg::st_data: begin
                    if (go && burst_valid) begin
                        sel.dat   <= 1'b1;
                        word_cnt  <= word_cnt + 23'd1;
                        burst_cnt <= burst_cnt + 14'd1;
                        if (burst_cnt + 14'd1 == cfg.num_bursts) begin
                            wave_cnt <= wave_cnt + 23'd1;
                            state    <= adc_acq_pkg::st_armed;
                        end
                    end
                end
                adc_acq_pkg::st_fill_hdr: begin
                    if (go) begin
                        sel.fill_hdr <= 1'b1;
                        word_cnt     <= word_cnt + 23'd2;   // fill header and checksum
                        state        <= adc_acq_pkg::st_checksum;
                    end
                end
                adc_acq_pkg::st_checksum: begin
                    if (go) begin
                        sel.chk <= 1'b1;
                        done    <= 1'b1;
                        state   <= adc_acq_pkg::st_idle;
                    end
                end
                default: state <= adc_acq_pkg::st_idle;
            endcase
        end
    end

    // trigger bookkeeping, only taken while armed
    always_ff @(posedge clk) begin
        if ((state == adc_acq_pkg::st_armed) && trigger) begin
            trig_time <= time_cnt;
            wave_adr  <= word_cnt;              // header goes to the next word slot
        end
    end

    // a select lands while the writer is still idle
    a_sel_ready: assert property (@(posedge clk) disable iff (!rst_n)
        sel_any |-> word_ready);

endmodule

`default_nettype wire

// File: hdl/burst_mux.sv
`default_nettype none
`include "adc_acq_macros.svh"

module burst_mux (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire adc_acq_pkg::word_sel_t   sel,
    input  wire adc_acq_pkg::acq_cfg_t    cfg,
    input  wire adc_acq_pkg::wave_info_t  info,
    input  wire adc_acq_pkg::burst_t      burst,
    output adc_acq_pkg::acq_word_t        out_word
);

    adc_acq_pkg::acq_word_t   fill_w;      // fill header
    adc_acq_pkg::acq_word_t   wave_w;      // waveform header
    adc_acq_pkg::acq_word_t   data_w;      // eight sign-extended samples
    adc_acq_pkg::acq_word_t   chosen;
    adc_acq_pkg::payload_t    checksum;    // running xor of payloads
    logic [`ACQ_SAMPLE_W:0]   half;        // one sample with over-range bit
    logic                     word_sel;

    assign word_sel = sel.fill_hdr || sel.wave_hdr || sel.dat || sel.chk;

    ////////////////////////////////////////////////////////////
    // header formats
    always_comb begin
        fill_w                   = '0;
        fill_w.tag               = `ACQ_TAG_FILL;
        fill_w.payload[23:0]     = cfg.fill_num;
        fill_w.payload[25:24]    = cfg.fill_type;
        fill_w.payload[49:27]    = info.num_fill_bursts;   // final word count
        fill_w.payload[63:50]    = cfg.num_bursts;
        fill_w.payload[75:64]    = cfg.pre_trig[11:0];
        fill_w.payload[98:76]    = info.waveform_num;      // final waveform count
        fill_w.payload[102:99]   = cfg.pre_trig[15:12];
        fill_w.payload[121:110]  = cfg.channel_tag;
        fill_w.payload[123]      = 1'b1;                   // self-trigger mode
        fill_w.payload[127:126]  = `ACQ_HDR_MARK;
    end

    always_comb begin
        wave_w                   = '0;
        wave_w.tag               = `ACQ_TAG_WAVE;
        wave_w.payload[13:0]     = cfg.num_bursts;
        wave_w.payload[25:14]    = cfg.pre_trig[13:2];
        wave_w.payload[48:26]    = info.waveform_start_adr;
        wave_w.payload[71:49]    = info.waveform_num;
        wave_w.payload[97:72]    = info.trigger_time[25:0];
        wave_w.payload[109:98]   = cfg.channel_tag;
        wave_w.payload[125:110]  = info.trigger_time[41:26];
        wave_w.payload[127:126]  = `ACQ_HDR_MARK;
    end

    ////////////////////////////////////////////////////////////
    // data lanes, lane 0 is pair 0 low half
    always_comb begin
        data_w     = '0;
        data_w.tag = `ACQ_TAG_DATA;
        half       = '0;
        for (int k = 0; k < 8; k++) begin
            half = burst[k / 2][13 * (k % 2) +: 13];
            data_w.payload[16 * k +: 16] = {{(16 - `ACQ_SAMPLE_W){half[`ACQ_SAMPLE_W]}},
                                            half[`ACQ_SAMPLE_W:1]};  // drop over-range bit
        end
    end

    always_comb begin
        if (sel.fill_hdr) chosen = fill_w;
        else if (sel.wave_hdr) chosen = wave_w;
        else if (sel.dat) chosen = data_w;
        else chosen = '{tag: `ACQ_TAG_CHK, payload: checksum};
    end

    always_ff @(posedge clk) begin
        if (!rst_n || sel.chk_init) checksum <= '0;
        else if (sel.fill_hdr || sel.wave_hdr || sel.dat) checksum <= checksum ^ chosen.payload;
    end

    always_ff @(posedge clk) begin
        if (word_sel) out_word <= chosen;     // held until the next select
    end

endmodule

`default_nettype wire

// File: hdl/wb_burst_writer.sv
`default_nettype none

module wb_burst_writer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          fill_start,
    input  wire adc_acq_pkg::acq_word_t  word,
    input  wire                          word_valid,
    output logic                         word_ready,
    output logic                         cyc,
    output logic                         stb,
    output logic                         we,
    output adc_acq_pkg::burst_cnt_t      adr,
    output adc_acq_pkg::acq_word_t       dat_o,
    input  wire                          ack
);

    logic busy;                             // bus cycle in progress

    assign word_ready = !busy;
    assign cyc        = busy;
    assign stb        = busy;               // one transfer per cycle
    assign we         = busy;               // write-only master

    ////////////////////////////////////////////////////////////
    // request and address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            adr  <= '0;
        end else begin
            if (!busy && word_valid) begin
                busy <= 1'b1;               // start the write
            end else if (busy && ack) begin
                busy <= 1'b0;               // ready again next cycle
            end
            if (fill_start) adr <= '0;
            else if (busy && ack) adr <= adr + 23'd1;   // consecutive word slots
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && word_valid) dat_o <= word;   // held through wait states
    end

    // slave may stretch the cycle, the request must not move
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stb && !ack |=> $stable(adr) && $stable(dat_o));

    // sequencer never hands over a word while a write is open
    a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
        word_valid |-> word_ready);

endmodule

`default_nettype wire

// File: hdl/adc_acq_selftrig.sv
`default_nettype none

module adc_acq_selftrig (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire adc_acq_pkg::pair_t      pair,
    input  wire                          pair_valid,
    input  wire                          trigger,
    input  wire                          fill_start,
    input  wire                          fill_stop,
    input  wire adc_acq_pkg::acq_cfg_t   cfg,
    output wire                          cyc,
    output wire                          stb,
    output wire                          we,
    output wire adc_acq_pkg::burst_cnt_t adr,
    output wire adc_acq_pkg::acq_word_t  dat_o,
    input  wire                          ack,
    output wire                          done,
    output wire                          overflow
);

    wire adc_acq_pkg::burst_t      burst;
    wire                           burst_valid;
    wire                           burst_take;
    wire                           word_ready;
    wire adc_acq_pkg::word_sel_t   sel;
    wire                           out_valid;
    wire adc_acq_pkg::wave_info_t  info;
    wire adc_acq_pkg::acq_word_t   out_word;

    sample_gather u_gather (
        .clk(clk), .rst_n(rst_n), .pair(pair), .pair_valid(pair_valid),
        .fill_start(fill_start), .burst_take(burst_take), .burst(burst),
        .burst_valid(burst_valid), .overflow(overflow)
    );

    fill_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .trigger(trigger), .fill_start(fill_start),
        .fill_stop(fill_stop), .cfg(cfg), .burst_valid(burst_valid),
        .burst_take(burst_take), .word_ready(word_ready), .sel(sel),
        .out_valid(out_valid), .info(info), .done(done)
    );

    burst_mux u_mux (
        .clk(clk), .rst_n(rst_n), .sel(sel), .cfg(cfg), .info(info),
        .burst(burst), .out_word(out_word)
    );

    wb_burst_writer u_wb (
        .clk(clk), .rst_n(rst_n), .fill_start(fill_start), .word(out_word),
        .word_valid(out_valid), .word_ready(word_ready), .cyc(cyc), .stb(stb),
        .we(we), .adr(adr), .dat_o(dat_o), .ack(ack)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;                   // period 4

endmodule

`default_nettype wire

// File: testbench/tb_adc_acq_selftrig.sv
`default_nettype none
`include "adc_acq_macros.svh"

module tb_adc_acq_selftrig;

    localparam int wait_limit = 500;        // cycles per wait loop
    localparam logic [127:0] time_mask = {2'b00, 16'hffff, 12'h000, 26'h3ffffff, 72'h0};

    wire                          clk;
    logic                         rst_n;
    adc_acq_pkg::pair_t           pair;
    logic                         pair_valid, trigger, fill_start, fill_stop, ack;
    adc_acq_pkg::acq_cfg_t        cfg;
    wire                          cyc, stb, we, done, overflow;
    wire adc_acq_pkg::burst_cnt_t adr;
    wire adc_acq_pkg::acq_word_t  dat_o;

    integer                  seed = 56;
    int                      errors, total_writes, n_writes, case_trig, case_num;
    int                      burst_pos, pair_slot, wait_left;
    bit                      in_req, hold_prev, send_samples, aborted;
    logic [127:0]            burst_q[$];    // expected data payload of every completed burst
    logic [127:0]            chk_model;
    logic [103:0]            stage_pairs;
    logic [41:0]             last_tt;
    adc_acq_pkg::burst_cnt_t prev_adr;
    adc_acq_pkg::acq_word_t  prev_dat;

    tb_clock_gen u_clk (.clk(clk));

    adc_acq_selftrig uut (
        .clk(clk), .rst_n(rst_n), .pair(pair), .pair_valid(pair_valid), .trigger(trigger),
        .fill_start(fill_start), .fill_stop(fill_stop), .cfg(cfg), .cyc(cyc), .stb(stb),
        .we(we), .adr(adr), .dat_o(dat_o), .ack(ack), .done(done), .overflow(overflow)
    );

    ////////////////////////////////////////////////////////////
    // expected word formats
    function automatic logic [127:0] data_exp(input logic [103:0] pairs);
        logic [127:0] p;
        logic [12:0]  half;
        p = '0;
        for (int k = 0; k < 8; k++) begin
            half = pairs[26 * (k / 2) + 13 * (k % 2) +: 13];
            p[16 * k +: 16] = {{4{half[12]}}, half[12:1]};   // sign extend, drop over-range
        end
        return p;
    endfunction

    function automatic logic [127:0] wave_exp(input adc_acq_pkg::acq_cfg_t c,
                                              input logic [22:0] idx, input logic [22:0] start);
        logic [127:0] p;
        p = '0;
        p[13:0]    = c.num_bursts;
        p[25:14]   = c.pre_trig[13:2];
        p[48:26]   = start;
        p[71:49]   = idx;
        p[109:98]  = c.channel_tag;
        p[127:126] = `ACQ_HDR_MARK;             // trigger time left out, see time_mask
        return p;
    endfunction

    function automatic logic [127:0] fill_exp(input adc_acq_pkg::acq_cfg_t c,
                                              input logic [22:0] waves, input logic [22:0] total);
        logic [127:0] p;
        p = '0;
        p[23:0]    = c.fill_num;
        p[25:24]   = c.fill_type;
        p[49:27]   = total;
        p[63:50]   = c.num_bursts;
        p[75:64]   = c.pre_trig[11:0];
        p[98:76]   = waves;
        p[102:99]  = c.pre_trig[15:12];
        p[121:110] = c.channel_tag;
        p[123]     = 1'b1;                      // self-trigger mode
        p[127:126] = `ACQ_HDR_MARK;
        return p;
    endfunction

    ////////////////////////////////////////////////////////////
    // reporting and waits
    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAIL @%0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("writes checked: %0d  errors: %0d", total_writes, errors);
        if (errors == 0) $display("All tests passed!");
        else $display("Test failures found");
        $finish;
    endtask

    task automatic note_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("timeout at %0t while waiting for %s in case %0d", $time, what, case_num);
    endtask

    task automatic step();
        @(posedge clk);
        #1;                                     // inputs change just after the edge
    endtask

    task automatic wait_writes(input int target, input string what);
        int cnt;
        cnt = 0;
        while (n_writes < target && cnt < wait_limit) begin
            step();
            cnt++;
        end
        if (n_writes < target) note_timeout(what);
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        while (!done && cnt < wait_limit) begin
            step();
            cnt++;
        end
        if (!done) note_timeout("done");
    endtask

    ////////////////////////////////////////////////////////////
    // check one completed write against the reference model
    task automatic record_write(input adc_acq_pkg::burst_cnt_t a,
                                input adc_acq_pkg::acq_word_t w);
        int           per, limit, wave_i;
        logic [3:0]   exp_tag;
        logic [41:0]  tt;
        bit           found;
        per   = cfg.num_bursts + 1;
        limit = case_trig * per;                // words before the fill header
        if (n_writes < limit) exp_tag = (n_writes % per == 0) ? `ACQ_TAG_WAVE : `ACQ_TAG_DATA;
        else if (n_writes == limit) exp_tag = `ACQ_TAG_FILL;
        else exp_tag = `ACQ_TAG_CHK;
        assert (a == n_writes)
            else report_mismatch($sformatf("adr %0d, expected %0d", a, n_writes));
        assert (w.tag == exp_tag)
            else report_mismatch($sformatf("word %0d tag %0d, expected %0d", n_writes, w.tag,
                                           exp_tag));
        case (exp_tag)
            `ACQ_TAG_WAVE: begin
                wave_i = n_writes / per;
                tt     = {w.payload[125:110], w.payload[97:72]};
                assert ((w.payload & ~time_mask) == wave_exp(cfg, wave_i, n_writes))
                    else report_mismatch($sformatf("waveform header %0d wrong: %h", wave_i,
                                                   w.payload));
                if (wave_i > 0) begin
                    assert (tt > last_tt)
                        else report_mismatch($sformatf("trigger time %0d not after %0d", tt,
                                                       last_tt));
                end
                last_tt = tt;
            end
            `ACQ_TAG_DATA: begin
                found = 1'b0;                   // bursts are taken in order, some get dropped
                for (int i = burst_pos; i < burst_q.size() && !found; i++) begin
                    if (burst_q[i] == w.payload) begin
                        found     = 1'b1;
                        burst_pos = i + 1;
                    end
                end
                assert (found)
                    else report_mismatch($sformatf("data word %0d matches no sent burst: %h",
                                                   n_writes, w.payload));
            end
            `ACQ_TAG_FILL: begin
                assert (w.payload == fill_exp(cfg, case_trig, limit + 2))
                    else report_mismatch($sformatf("fill header wrong: %h", w.payload));
            end
            default: begin
                assert (w.payload == chk_model)
                    else report_mismatch($sformatf("checksum %h, expected %h", w.payload,
                                                   chk_model));
            end
        endcase
        if (exp_tag != `ACQ_TAG_CHK) chk_model = chk_model ^ w.payload;
        n_writes++;
        total_writes++;
    endtask

    // wishbone slave with random wait states
    always @(posedge clk) begin
        if (!rst_n) begin
            in_req    = 1'b0;
            hold_prev = 1'b0;
        end else begin
            if (hold_prev && cyc && stb) begin
                assert (adr == prev_adr && dat_o == prev_dat)
                    else report_mismatch("adr or dat_o changed before ack");
            end
            hold_prev = cyc && stb && !ack;
            prev_adr  = adr;
            prev_dat  = dat_o;
            if (cyc && stb && ack) begin        // transfer ends at this edge
                in_req = 1'b0;
                assert (we) else report_mismatch("write cycle without we");
                record_write(adr, dat_o);
                #1 ack = 1'b0;
            end else if (cyc && stb) begin
                if (!in_req) begin
                    in_req    = 1'b1;
                    wait_left = {$random(seed)} % 4;
                end
                if (wait_left == 0) #1 ack = 1'b1;
                else wait_left--;
            end
        end
    end

    // one sample pair per cycle, expected payload kept per completed burst
    always @(posedge clk) begin
        #1;
        if (send_samples) begin
            pair       = $random(seed);
            pair_valid = 1'b1;
            stage_pairs[26 * pair_slot +: 26] = pair;
            if (pair_slot == 3) burst_q.push_back(data_exp(stage_pairs));
            pair_slot  = (pair_slot + 1) % 4;
        end else begin
            pair_valid = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // case runner
    task automatic run_case(input adc_acq_pkg::acq_cfg_t c, input int trig_n,
                            input int exp_words);
        int per;
        per        = c.num_bursts + 1;
        cfg        = c;
        case_trig  = trig_n;
        n_writes   = 0;
        chk_model  = '0;
        fill_start = 1'b1;
        step();
        fill_start = 1'b0;
        repeat (12) step();                     // no trigger pending, bursts pile up
        for (int t = 0; t < trig_n; t++) begin
            trigger = 1'b1;
            step();
            trigger = 1'b0;
            wait_writes((t + 1) * per, "waveform words");
            if (aborted) return;
            repeat (5) step();
        end
        fill_stop = 1'b1;
        step();
        fill_stop = 1'b0;
        wait_done();
        if (aborted) return;
        wait_writes(exp_words, "fill header and checksum");
        if (aborted) return;
        repeat (10) step();                     // catch any extra write
        assert (n_writes == exp_words)
            else report_mismatch($sformatf("case %0d wrote %0d words, expected %0d", case_num,
                                           n_writes, exp_words));
    endtask

    initial begin
        int                    fd, r, n, nb, trig_n, exp_words;
        string                 line;
        logic [11:0]           ch;
        logic [23:0]           fnum;
        logic [1:0]            ftype;
        logic [15:0]           pt;
        adc_acq_pkg::acq_cfg_t c;
        errors = 0;
        total_writes = 0;
        case_num = 0;
        burst_pos = 0;
        pair_slot = 0;
        send_samples = 1'b0;
        aborted = 1'b0;
        rst_n = 1'b0;
        pair = '0;
        pair_valid = 1'b0;
        trigger = 1'b0;
        fill_start = 1'b0;
        fill_stop = 1'b0;
        ack = 1'b0;
        cfg = '0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        step();
        send_samples = 1'b1;
        assert (!cyc && !stb && !we && !done && !overflow)
            else report_mismatch("outputs not idle after reset");
        fd = $fopen("testbench/acq_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open testbench/acq_cases.txt");
        end else begin
            while (!$feof(fd) && !aborted) begin
                r = $fgets(line, fd);
                if (r > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %d %h %d %d", ch, fnum, ftype, nb, pt,
                                trig_n, exp_words);
                    if (n == 7) begin
                        case_num++;
                        c = '{channel_tag: ch, fill_num: fnum, fill_type: ftype,
                              num_bursts: nb[13:0], pre_trig: pt};
                        run_case(c, trig_n, exp_words);
                    end
                end
            end
            $fclose(fd);
            if (case_num == 0) begin
                errors++;
                $display("no test cases were read from testbench/acq_cases.txt");
            end else if (!aborted) begin
                assert (overflow) else report_mismatch("overflow not set after the last fill");
                send_samples = 1'b0;
                repeat (2) step();
                fill_start = 1'b1;
                step();
                fill_start = 1'b0;
                assert (!overflow) else report_mismatch("overflow not cleared by fill_start");
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: testbench/acq_cases.txt
# channel_tag fill_num fill_type num_bursts pre_trig triggers expected_words
# hex hex hex dec hex dec dec, expected_words = triggers * (num_bursts + 1) + 2
a5c 000001 0 4 1234 2 12
3f1 0abcde 1 1 ffff 3 8
001 fffffe 2 7 8001 1 10
e07 123456 3 3 0a5a 4 18
7ff 000100 1 2 00f0 0 2
b3c 55aa55 2 5 4321 3 20

// File: adc_acq_selftrig.f
+incdir+hdl
hdl/adc_acq_pkg.sv
hdl/sample_gather.sv
hdl/fill_sequencer.sv
hdl/burst_mux.sv
hdl/wb_burst_writer.sv
hdl/adc_acq_selftrig.sv
testbench/tb_clock_gen.sv
testbench/tb_adc_acq_selftrig.sv
